//--- hdl/rv64_pkg.sv
package rv64_pkg;

	// =========================================================================
	// widths and opcodes
	// =========================================================================

	// data width of the engine
	// dec_t.imm and wb_t.data are fixed at 64 bits so a top level stays at 64
	localparam int XLEN = 64;

	localparam logic [6:0] op_lui     = 7'b0110111;
	localparam logic [6:0] op_auipc   = 7'b0010111;
	localparam logic [6:0] op_jal     = 7'b1101111;
	localparam logic [6:0] op_jalr    = 7'b1100111;
	localparam logic [6:0] op_branch  = 7'b1100011;
	localparam logic [6:0] op_imm     = 7'b0010011;
	localparam logic [6:0] op_imm_32  = 7'b0011011;
	localparam logic [6:0] op_op      = 7'b0110011;
	localparam logic [6:0] op_op_32   = 7'b0111011;
	localparam logic [6:0] op_system  = 7'b1110011;
	// only used to classify the S format
	localparam logic [6:0] op_store   = 7'b0100011;

	// =========================================================================
	// operand selects and ALU operations
	// =========================================================================

	typedef enum logic {
		v1_rs1 = 1'b0,
		v1_pc  = 1'b1
	} v1_sel_t;

	typedef enum logic {
		v2_rs2 = 1'b0,
		v2_imm = 1'b1
	} v2_sel_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_t;

	// =========================================================================
	// decoded instruction and write-back event
	// =========================================================================

	typedef struct packed {
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [2:0]  funct3;
		logic        alt;
		logic [63:0] imm;
		v1_sel_t     v1_sel;
		v2_sel_t     v2_sel;
		logic        is_word;
		logic        is_branch;
		logic        is_jal;
		logic        is_jalr;
		logic        is_mul;
		logic        is_ebreak;
		logic        writes_rd;
	} dec_t;

	typedef struct packed {
		logic        valid;
		logic [4:0]  rd;
		logic [63:0] data;
	} wb_t;

endpackage

//--- hdl/rv64_decode.sv
`timescale 1ns/10ps

module rv64_decode (
	input  logic [31:0]    instr,
	output rv64_pkg::dec_t dec
);

	logic [6:0]  opcode;
	logic        i_fmt;
	logic        u_fmt;
	logic        j_fmt;
	logic        b_fmt;
	logic        s_fmt;
	logic        r_fmt;
	logic        imm_alu;
	logic [63:0] i_imm;
	logic [63:0] u_imm;
	logic [63:0] j_imm;
	logic [63:0] b_imm;
	logic [63:0] s_imm;

	assign opcode = instr[6:0];

	// format classes
	assign i_fmt = (opcode == rv64_pkg::op_jalr) | (opcode == rv64_pkg::op_imm) |
		(opcode == rv64_pkg::op_imm_32) | (opcode == rv64_pkg::op_system);
	assign u_fmt = (opcode == rv64_pkg::op_lui) | (opcode == rv64_pkg::op_auipc);
	assign j_fmt = (opcode == rv64_pkg::op_jal);
	assign b_fmt = (opcode == rv64_pkg::op_branch);
	assign s_fmt = (opcode == rv64_pkg::op_store);
	assign r_fmt = (opcode == rv64_pkg::op_op) | (opcode == rv64_pkg::op_op_32);

	assign imm_alu = (opcode == rv64_pkg::op_imm) | (opcode == rv64_pkg::op_imm_32);

	// sign-extended immediates per format
	assign i_imm = {{52{instr[31]}}, instr[31:20]};
	assign u_imm = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign j_imm = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign b_imm = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign s_imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};

	always_comb begin
		dec.rs1 = instr[19:15];
		dec.rs2 = instr[24:20];
		dec.rd  = instr[11:7];

		// U and J formats have no funct3, force add
		dec.funct3 = (u_fmt | j_fmt) ? 3'b000 : instr[14:12];

		// alt only means sub or sra where the encoding defines it
		// lui borrows funct3 000 with alt set to pass the immediate
		if (r_fmt)
			dec.alt = instr[30];
		else if (imm_alu && (instr[14:12] == 3'b101))
			dec.alt = instr[30];
		else if (opcode == rv64_pkg::op_lui)
			dec.alt = 1'b1;
		else
			dec.alt = 1'b0;

		if (i_fmt)
			dec.imm = i_imm;
		else if (u_fmt)
			dec.imm = u_imm;
		else if (j_fmt)
			dec.imm = j_imm;
		else if (b_fmt)
			dec.imm = b_imm;
		else if (s_fmt)
			dec.imm = s_imm;
		else
			dec.imm = '0;

		// operand sources
		dec.v1_sel = (j_fmt | b_fmt | (opcode == rv64_pkg::op_auipc)) ?
			rv64_pkg::v1_pc : rv64_pkg::v1_rs1;
		dec.v2_sel = r_fmt ? rv64_pkg::v2_rs2 : rv64_pkg::v2_imm;

		dec.is_word   = (opcode == rv64_pkg::op_imm_32) | (opcode == rv64_pkg::op_op_32);
		dec.is_branch = b_fmt;
		dec.is_jal    = j_fmt;
		dec.is_jalr   = (opcode == rv64_pkg::op_jalr);
		dec.is_mul    = r_fmt & instr[25];
		dec.is_ebreak = (opcode == rv64_pkg::op_system) && (instr[31:20] == 12'h001);
		// x0 writes are dropped here so no wb pulse is ever raised for them
		dec.writes_rd = (instr[11:7] != 5'd0) &
			(u_fmt | j_fmt | dec.is_jalr | imm_alu | r_fmt);
	end

endmodule

//--- hdl/rv64_regfile.sv
`timescale 1ns/10ps

module rv64_regfile #(
	parameter int XLEN = rv64_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  rv64_pkg::wb_t   wb,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.valid && (wb.rd != 5'd0)) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// x0 never takes a write so it reads zero
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

endmodule

//--- hdl/rv64_alu.sv
`timescale 1ns/10ps

module rv64_alu #(
	parameter int XLEN = rv64_pkg::XLEN
) (
	input  rv64_pkg::dec_t  dec,
	input  logic [XLEN-1:0] rs1_data,
	input  logic [XLEN-1:0] rs2_data,
	input  logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] result,
	output logic [XLEN-1:0] next_pc,
	output logic            taken
);

	localparam int SH_W = $clog2(XLEN);

	logic [XLEN-1:0]   op_a;
	logic [XLEN-1:0]   op_b;
	logic [XLEN-1:0]   sum;
	logic [XLEN-1:0]   pc_inc;
	logic [XLEN-1:0]   word_a_zx;
	logic [XLEN-1:0]   word_a_sx;
	logic [XLEN-1:0]   raw;
	logic [SH_W-1:0]   shamt;
	logic              cond;
	rv64_pkg::alu_op_t alu_op;

	assign op_a = (dec.v1_sel == rv64_pkg::v1_pc) ? pc : rs1_data;
	assign op_b = (dec.v2_sel == rv64_pkg::v2_imm) ? dec.imm[XLEN-1:0] : rs2_data;

	// also the branch, jal and jalr target
	assign sum    = op_a + op_b;
	assign pc_inc = pc + XLEN'(4);

	// word shifts work on the low half only
	assign word_a_zx = {{(XLEN-32){1'b0}}, op_a[31:0]};
	assign word_a_sx = {{(XLEN-32){op_a[31]}}, op_a[31:0]};
	assign shamt     = dec.is_word ? SH_W'(op_b[4:0]) : op_b[SH_W-1:0];

	// =========================================================================
	// operation select
	// =========================================================================

	always_comb begin
		if (dec.is_jal || dec.is_jalr || dec.is_branch) begin
			alu_op = rv64_pkg::alu_add;
		end else begin
			case (dec.funct3)
				3'b000: begin
					if (!dec.alt)
						alu_op = rv64_pkg::alu_add;
					else if (dec.v2_sel == rv64_pkg::v2_rs2)
						alu_op = rv64_pkg::alu_sub;
					else
						alu_op = rv64_pkg::alu_pass_b;
				end
				3'b001:  alu_op = rv64_pkg::alu_sll;
				3'b010:  alu_op = rv64_pkg::alu_slt;
				3'b011:  alu_op = rv64_pkg::alu_sltu;
				3'b100:  alu_op = rv64_pkg::alu_xor;
				3'b101:  alu_op = dec.alt ? rv64_pkg::alu_sra : rv64_pkg::alu_srl;
				3'b110:  alu_op = rv64_pkg::alu_or;
				default: alu_op = rv64_pkg::alu_and;
			endcase
		end
	end

	always_comb begin
		case (alu_op)
			rv64_pkg::alu_add:    raw = sum;
			rv64_pkg::alu_sub:    raw = op_a - op_b;
			rv64_pkg::alu_sll:    raw = op_a << shamt;
			rv64_pkg::alu_slt:    raw = {{(XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			rv64_pkg::alu_sltu:   raw = {{(XLEN-1){1'b0}}, (op_a < op_b)};
			rv64_pkg::alu_xor:    raw = op_a ^ op_b;
			rv64_pkg::alu_srl:    raw = (dec.is_word ? word_a_zx : op_a) >> shamt;
			rv64_pkg::alu_sra:    raw = $signed(dec.is_word ? word_a_sx : op_a) >>> shamt;
			rv64_pkg::alu_or:     raw = op_a | op_b;
			rv64_pkg::alu_and:    raw = op_a & op_b;
			rv64_pkg::alu_pass_b: raw = op_b;
			default:              raw = sum;
		endcase
	end

	// link value for jumps, sign-extended low word for *W ops
	always_comb begin
		if (dec.is_jal || dec.is_jalr)
			result = pc_inc;
		else if (dec.is_word)
			result = {{(XLEN-32){raw[31]}}, raw[31:0]};
		else
			result = raw;
	end

	// =========================================================================
	// branch compare and next pc
	// =========================================================================

	always_comb begin
		case (dec.funct3)
			3'b000:  cond = (rs1_data == rs2_data);
			3'b001:  cond = (rs1_data != rs2_data);
			3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
			3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
			3'b110:  cond = (rs1_data < rs2_data);
			3'b111:  cond = (rs1_data >= rs2_data);
			default: cond = 1'b0;
		endcase
	end

	assign taken = dec.is_branch & cond;

	always_comb begin
		if (dec.is_jal || taken)
			next_pc = sum;
		else if (dec.is_jalr)
			next_pc = {sum[XLEN-1:1], 1'b0};
		else
			next_pc = pc_inc;
	end

endmodule

//--- hdl/rv64_step_counter.sv
`timescale 1ns/10ps

module rv64_step_counter #(
	parameter int STEPS = rv64_pkg::XLEN
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic step,
	output logic last
);

	localparam int CW = (STEPS > 1) ? $clog2(STEPS) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (start) begin
			cnt <= CW'(STEPS - 1);
		end else if (step && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	// final step is the one taken at count zero
	assign last = step && (cnt == '0);

endmodule

//--- hdl/rv64_mul_iter.sv
`timescale 1ns/10ps

module rv64_mul_iter #(
	parameter int XLEN = rv64_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start,
	input  logic            step,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] product
);

	// multiplicand moves left, multiplier moves right
	logic [XLEN-1:0] mcand;
	logic [XLEN-1:0] mplier;
	logic [XLEN-1:0] acc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
		end else if (start) begin
			acc <= '0;
		end else if (step && mplier[0]) begin
			// bits above XLEN fall off, only the low product is kept
			acc <= acc + mcand;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand  <= a;
			mplier <= b;
		end else if (step) begin
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign product = acc;

endmodule

//--- hdl/rv64_ctrl_fsm.sv
`timescale 1ns/10ps

module rv64_ctrl_fsm #(
	parameter int XLEN = rv64_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [31:0]     instr,
	input  logic            instr_valid,
	input  rv64_pkg::dec_t  dec,
	input  logic [XLEN-1:0] alu_result,
	input  logic [XLEN-1:0] next_pc,
	input  logic [XLEN-1:0] product,
	input  logic            last,
	output logic            ready,
	output logic [31:0]     ir,
	output logic [XLEN-1:0] pc,
	output logic            start,
	output logic            step,
	output rv64_pkg::wb_t   wb,
	output logic            halted
);

	typedef enum logic [2:0] {
		s_idle,
		s_exec,
		s_mul,
		s_wb,
		s_halt
	} state_t;

	state_t state;
	state_t state_nxt;

	// =========================================================================
	// state sequencing
	// =========================================================================

	always_comb begin
		state_nxt = state;
		case (state)
			s_idle:  if (instr_valid) state_nxt = s_exec;
			s_exec:  state_nxt = dec.is_mul ? s_mul : s_wb;
			s_mul:   if (last) state_nxt = s_wb;
			s_wb:    state_nxt = dec.is_ebreak ? s_halt : s_idle;
			s_halt:  state_nxt = s_halt;
			default: state_nxt = s_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s_idle;
			ir    <= '0;
			pc    <= '0;
		end else begin
			state <= state_nxt;
			// strobes outside idle are dropped
			if ((state == s_idle) && instr_valid)
				ir <= instr;
			// a halted engine keeps pointing at its ebreak
			if ((state == s_wb) && !dec.is_ebreak)
				pc <= next_pc;
		end
	end

	// =========================================================================
	// outputs
	// =========================================================================

	assign ready  = (state == s_idle);
	assign halted = (state == s_halt);
	assign start  = (state == s_exec) && dec.is_mul;
	assign step   = (state == s_mul);

	// register reads stay unchanged through wb since the write lands at its end
	always_comb begin
		wb.valid = (state == s_wb) && dec.writes_rd;
		wb.rd    = dec.rd;
		wb.data  = dec.is_mul ? product : alu_result;
	end

endmodule

//--- hdl/rv64_exec_top.sv
`timescale 1ns/10ps

module rv64_exec_top #(
	parameter int XLEN = rv64_pkg::XLEN
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [31:0]     instr,
	input  logic            instr_valid,
	output logic            ready,
	output logic [XLEN-1:0] pc,
	output rv64_pkg::wb_t   wb,
	output logic            halted
);

	logic [31:0]     ir;
	rv64_pkg::dec_t  dec;
	logic [XLEN-1:0] rs1_data;
	logic [XLEN-1:0] rs2_data;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] next_pc;
	logic [XLEN-1:0] product;
	logic            start;
	logic            step;
	logic            last;

	rv64_decode u_decode (
		.instr (ir),
		.dec   (dec)
	);

	rv64_regfile #(.XLEN(XLEN)) u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (dec.rs1),
		.rs2      (dec.rs2),
		.wb       (wb),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	// branch outcome is already folded into next_pc
	rv64_alu #(.XLEN(XLEN)) u_alu (
		.dec      (dec),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.pc       (pc),
		.result   (alu_result),
		.next_pc  (next_pc),
		.taken    ()
	);

	// one step per multiplier bit
	rv64_step_counter #(.STEPS(XLEN)) u_step_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.start (start),
		.step  (step),
		.last  (last)
	);

	rv64_mul_iter #(.XLEN(XLEN)) u_mul_iter (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.step    (step),
		.a       (rs1_data),
		.b       (rs2_data),
		.product (product)
	);

	rv64_ctrl_fsm #(.XLEN(XLEN)) u_ctrl_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.dec         (dec),
		.alu_result  (alu_result),
		.next_pc     (next_pc),
		.product     (product),
		.last        (last),
		.ready       (ready),
		.ir          (ir),
		.pc          (pc),
		.start       (start),
		.step        (step),
		.wb          (wb),
		.halted      (halted)
	);

endmodule

//--- dv/rv64_exec_tb.sv
`timescale 1ns/10ps

module rv64_exec_tb;

	localparam int XLEN = rv64_pkg::XLEN;

	logic            clk;
	logic            rst_n;
	logic [31:0]     instr;
	logic            instr_valid;
	logic            ready;
	logic [XLEN-1:0] pc;
	rv64_pkg::wb_t   wb;
	logic            halted;

	// shadow state of the reference model
	logic [63:0] regs_m [32];
	logic [63:0] pc_m;
	bit          halt_m;
	integer      seed;

	rv64_exec_top #(.XLEN(XLEN)) uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr       (instr),
		.instr_valid (instr_valid),
		.ready       (ready),
		.pc          (pc),
		.wb          (wb),
		.halted      (halted)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==========================================================================
	// failure reporting and instruction encoders
	// ==========================================================================

	task automatic fail_run();
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("error %s: expected %h, actual %h", name, exp, act);
		fail_run();
	endtask

	function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] b_format(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv64_pkg::op_branch};
	endfunction

	function automatic logic [31:0] j_format(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rv64_pkg::op_jal};
	endfunction

	// ==========================================================================
	// reference model with RV64 semantics
	// ==========================================================================

	function automatic logic [63:0] int_result(input logic [2:0] f3, input bit alt,
		input logic [63:0] x, input logic [63:0] y);
		logic [63:0] r;
		case (f3)
			3'b000: r = alt ? x - y : x + y;
			3'b001: r = x << y[5:0];
			3'b010: r = ($signed(x) < $signed(y)) ? 64'd1 : 64'd0;
			3'b011: r = (x < y) ? 64'd1 : 64'd0;
			3'b100: r = x ^ y;
			3'b101: begin
				if (alt)
					r = $signed(x) >>> y[5:0];
				else
					r = x >> y[5:0];
			end
			3'b110: r = x | y;
			default: r = x & y;
		endcase
		return r;
	endfunction

	function automatic logic [63:0] word_result(input logic [2:0] f3, input bit alt,
		input logic [63:0] x, input logic [63:0] y);
		logic [31:0] xl;
		logic [31:0] lo;
		xl = x[31:0];
		if (f3 == 3'b001)
			lo = xl << y[4:0];
		else if (f3 == 3'b101 && alt)
			lo = $signed(xl) >>> y[4:0];
		else if (f3 == 3'b101)
			lo = xl >> y[4:0];
		else if (alt)
			lo = xl - y[31:0];
		else
			lo = xl + y[31:0];
		return {{32{lo[31]}}, lo};
	endfunction

	// predicts the write-back of one instruction and advances the shadow state
	task automatic predict(input logic [31:0] w, output bit we, output logic [4:0] rd,
		output logic [63:0] data);
		logic [63:0] a;
		logic [63:0] b;
		logic [63:0] imm_i;
		logic [63:0] imm_u;
		logic [63:0] imm_b;
		logic [63:0] imm_j;
		logic [63:0] npc;
		logic [2:0]  f3;
		bit          cond;
		a = regs_m[w[19:15]];
		b = regs_m[w[24:20]];
		f3 = w[14:12];
		rd = w[11:7];
		imm_i = {{52{w[31]}}, w[31:20]};
		imm_u = {{32{w[31]}}, w[31:12], 12'h000};
		imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		we = 1'b1;
		data = '0;
		npc = pc_m + 64'd4;
		case (w[6:0])
			rv64_pkg::op_lui:    data = imm_u;
			rv64_pkg::op_auipc:  data = pc_m + imm_u;
			rv64_pkg::op_imm:    data = int_result(f3, (f3 == 3'b101) && w[30], a, imm_i);
			rv64_pkg::op_imm_32: data = word_result(f3, (f3 == 3'b101) && w[30], a, imm_i);
			rv64_pkg::op_op_32:  data = word_result(f3, w[30], a, b);
			rv64_pkg::op_op: begin
				if (w[25])
					data = a * b;
				else
					data = int_result(f3, w[30], a, b);
			end
			rv64_pkg::op_jal: begin
				data = pc_m + 64'd4;
				npc = pc_m + imm_j;
			end
			rv64_pkg::op_jalr: begin
				data = pc_m + 64'd4;
				npc = (a + imm_i) & ~64'd1;
			end
			rv64_pkg::op_branch: begin
				we = 1'b0;
				case (f3)
					3'b000:  cond = (a == b);
					3'b001:  cond = (a != b);
					3'b100:  cond = ($signed(a) < $signed(b));
					3'b101:  cond = ($signed(a) >= $signed(b));
					3'b110:  cond = (a < b);
					default: cond = (a >= b);
				endcase
				if (cond)
					npc = pc_m + imm_b;
			end
			default: begin
				// ebreak leaves the pc on itself
				we = 1'b0;
				npc = pc_m;
				halt_m = 1'b1;
			end
		endcase
		if (rd == 5'd0)
			we = 1'b0;
		if (we)
			regs_m[rd] = data;
		pc_m = npc;
	endtask

	// ==========================================================================
	// issue and check
	// ==========================================================================

	task automatic wait_ready(input int limit, output bit seen);
		int n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < limit) begin
			@(negedge clk);
			seen = ready;
			n++;
		end
	endtask

	// busy_strobe raises a second strobe while the engine is still working
	task automatic run_instr(input string name, input logic [31:0] w, input bit busy_strobe);
		bit          seen;
		bit          exp_we;
		logic [4:0]  exp_rd;
		logic [63:0] exp_data;
		int          lat;
		wait_ready(20, seen);
		if (!seen) begin
			$display("%s: ready stayed low, the instruction could not be issued", name);
			fail_run();
		end
		lat = (w[6:0] == rv64_pkg::op_op && w[25]) ? XLEN + 2 : 2;
		predict(w, exp_we, exp_rd, exp_data);
		@(posedge clk);
		instr <= w;
		instr_valid <= 1'b1;
		for (int k = 1; k <= lat + 1; k++) begin
			@(posedge clk);
			if (busy_strobe && k == 4) begin
				instr <= i_format(12'h3a5, 5'd0, 3'b000, 5'd5, rv64_pkg::op_imm);
				instr_valid <= 1'b1;
			end else begin
				instr_valid <= 1'b0;
			end
			@(negedge clk);
			if (k < lat) begin
				assert (ready == 1'b0) else report_mismatch({name, " ready"}, 0, ready);
				assert (wb.valid == 1'b0)
					else report_mismatch({name, " wb.valid"}, 0, wb.valid);
			end else if (k == lat) begin
				assert (ready == 1'b0) else report_mismatch({name, " ready"}, 0, ready);
				assert (wb.valid == exp_we)
					else report_mismatch({name, " wb.valid"}, exp_we, wb.valid);
				if (exp_we) begin
					assert (wb.rd == exp_rd) else report_mismatch({name, " wb.rd"}, exp_rd, wb.rd);
					assert (wb.data == exp_data)
						else report_mismatch({name, " wb.data"}, exp_data, wb.data);
				end
			end else begin
				assert (pc == pc_m) else report_mismatch({name, " pc"}, pc_m, pc);
				assert (halted == halt_m) else report_mismatch({name, " halted"}, halt_m, halted);
				assert (ready == !halt_m) else report_mismatch({name, " ready"}, !halt_m, ready);
				// the write-back is a single-cycle pulse
				assert (wb.valid == 1'b0)
					else report_mismatch({name, " wb.valid after pulse"}, 0, wb.valid);
			end
		end
	endtask

	// ==========================================================================
	// test sequences
	// ==========================================================================

	task automatic seed_registers();
		logic [31:0] rnd;
		logic [4:0]  r;
		for (int i = 1; i < 32; i++) begin
			r = i;
			rnd = $random(seed);
			run_instr("seed_lui", u_format(rnd[19:0], r, rv64_pkg::op_lui), 1'b0);
			run_instr("seed_addi", i_format(rnd[31:20], r, 3'b000, r, rv64_pkg::op_imm), 1'b0);
			rnd = $random(seed);
			run_instr("seed_slli", i_format({7'd0, rnd[4:0]}, r, 3'b001, r, rv64_pkg::op_imm),
				1'b0);
		end
	endtask

	task automatic random_alu_program(input int count);
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [2:0]  f3;
		logic [2:0]  f3w;
		logic [6:0]  f7;
		logic [11:0] imm;
		logic [31:0] w;
		for (int n = 0; n < count; n++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			f3 = rnd[17:15];
			f3w = (rnd[16:15] == 2'd0) ? 3'b000 : ((rnd[16:15] == 2'd1) ? 3'b001 : 3'b101);
			case (rnd[21:20])
				2'd0: begin
					f7 = (rnd[18] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'd0;
					w = r_format(f7, rnd[14:10], rnd[9:5], f3, rnd[4:0], rv64_pkg::op_op);
				end
				2'd1: begin
					if (f3 == 3'b001)
						imm = {6'd0, rnd2[5:0]};
					else if (f3 == 3'b101)
						imm = {1'b0, rnd[18], 4'd0, rnd2[5:0]};
					else
						imm = rnd2[11:0];
					w = i_format(imm, rnd[9:5], f3, rnd[4:0], rv64_pkg::op_imm);
				end
				2'd2: begin
					f7 = (rnd[18] && f3w != 3'b001) ? 7'b0100000 : 7'd0;
					w = r_format(f7, rnd[14:10], rnd[9:5], f3w, rnd[4:0], rv64_pkg::op_op_32);
				end
				default: begin
					if (f3w == 3'b000)
						imm = rnd2[11:0];
					else
						imm = {1'b0, rnd[18] && (f3w == 3'b101), 5'd0, rnd2[4:0]};
					w = i_format(imm, rnd[9:5], f3w, rnd[4:0], rv64_pkg::op_imm_32);
				end
			endcase
			run_instr("random_alu", w, 1'b0);
		end
	endtask

	task automatic immediate_cases();
		logic [11:0] imm12 [4];
		logic [19:0] imm20 [3];
		imm12 = '{12'h7ff, 12'h800, 12'hfff, 12'h001};
		imm20 = '{20'h80000, 20'h7ffff, 20'hfffff};
		foreach (imm12[i]) begin
			run_instr("imm_addi", i_format(imm12[i], 5'd7, 3'b000, 5'd6, rv64_pkg::op_imm), 1'b0);
			run_instr("imm_slti", i_format(imm12[i], 5'd7, 3'b010, 5'd8, rv64_pkg::op_imm), 1'b0);
			run_instr("imm_sltiu", i_format(imm12[i], 5'd7, 3'b011, 5'd9, rv64_pkg::op_imm),
				1'b0);
			run_instr("imm_xori", i_format(imm12[i], 5'd7, 3'b100, 5'd10, rv64_pkg::op_imm),
				1'b0);
			run_instr("imm_addiw", i_format(imm12[i], 5'd7, 3'b000, 5'd13,
				rv64_pkg::op_imm_32), 1'b0);
		end
		foreach (imm20[i]) begin
			run_instr("imm_lui", u_format(imm20[i], 5'd11, rv64_pkg::op_lui), 1'b0);
			run_instr("imm_auipc", u_format(imm20[i], 5'd12, rv64_pkg::op_auipc), 1'b0);
		end
	endtask

	task automatic control_flow_cases();
		logic [2:0]  kinds [6];
		logic [31:0] rnd;
		kinds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		// -5, 7 and 7 give both outcomes for every compare
		run_instr("cf_setup", i_format(12'hffb, 5'd0, 3'b000, 5'd14, rv64_pkg::op_imm), 1'b0);
		run_instr("cf_setup", i_format(12'h007, 5'd0, 3'b000, 5'd15, rv64_pkg::op_imm), 1'b0);
		run_instr("cf_setup", i_format(12'h007, 5'd0, 3'b000, 5'd16, rv64_pkg::op_imm), 1'b0);
		foreach (kinds[i]) begin
			rnd = $random(seed);
			run_instr("branch", b_format({rnd[11:0], 1'b0}, 5'd15, 5'd14, kinds[i]), 1'b0);
			run_instr("branch", b_format({rnd[23:12], 1'b0}, 5'd16, 5'd15, kinds[i]), 1'b0);
			run_instr("branch", b_format({rnd[31:20], 1'b0}, 5'd14, 5'd15, kinds[i]), 1'b0);
		end
		run_instr("jal_fwd", j_format(21'h000100, 5'd1), 1'b0);
		run_instr("jal_back", j_format(21'h1ff000, 5'd2), 1'b0);
		run_instr("jal_x0", j_format(21'h000040, 5'd0), 1'b0);
		run_instr("cf_setup", i_format(12'h101, 5'd0, 3'b000, 5'd17, rv64_pkg::op_imm), 1'b0);
		run_instr("jalr_odd", i_format(12'h000, 5'd17, 3'b000, 5'd3, rv64_pkg::op_jalr), 1'b0);
		run_instr("jalr_neg", i_format(12'hffe, 5'd17, 3'b000, 5'd4, rv64_pkg::op_jalr), 1'b0);
		run_instr("jalr_x0", i_format(12'h004, 5'd17, 3'b000, 5'd0, rv64_pkg::op_jalr), 1'b0);
	endtask

	task automatic mul_cases();
		logic [31:0] rnd;
		// zero, all ones and the top bit alone
		run_instr("mul_setup", i_format(12'h000, 5'd0, 3'b000, 5'd20, rv64_pkg::op_imm), 1'b0);
		run_instr("mul_setup", i_format(12'hfff, 5'd0, 3'b000, 5'd21, rv64_pkg::op_imm), 1'b0);
		run_instr("mul_setup", i_format(12'h001, 5'd0, 3'b000, 5'd22, rv64_pkg::op_imm), 1'b0);
		run_instr("mul_setup", i_format(12'h03f, 5'd22, 3'b001, 5'd22, rv64_pkg::op_imm), 1'b0);
		run_instr("mul_ones", r_format(7'd1, 5'd21, 5'd21, 3'b000, 5'd23, rv64_pkg::op_op), 1'b0);
		run_instr("mul_zero", r_format(7'd1, 5'd20, 5'd21, 3'b000, 5'd24, rv64_pkg::op_op), 1'b0);
		run_instr("mul_high", r_format(7'd1, 5'd21, 5'd22, 3'b000, 5'd25, rv64_pkg::op_op), 1'b0);
		run_instr("mul_busy", r_format(7'd1, 5'd22, 5'd22, 3'b000, 5'd26, rv64_pkg::op_op), 1'b1);
		for (int n = 0; n < 6; n++) begin
			rnd = $random(seed);
			run_instr("mul_random", r_format(7'd1, rnd[14:10], rnd[9:5], 3'b000, rnd[4:0],
				rv64_pkg::op_op), 1'b0);
		end
	endtask

	task automatic ebreak_cases();
		bit          seen;
		logic [31:0] rnd;
		run_instr("ebreak", i_format(12'h001, 5'd0, 3'b000, 5'd0, rv64_pkg::op_system), 1'b0);
		// a timeout is the expected outcome here
		wait_ready(20, seen);
		if (seen) begin
			$display("ready rose again after ebreak had halted the engine");
			fail_run();
		end
		for (int n = 0; n < 8; n++) begin
			rnd = $random(seed);
			@(posedge clk);
			instr <= i_format(rnd[11:0], 5'd0, 3'b000, rnd[16:12], rv64_pkg::op_imm);
			instr_valid <= 1'b1;
			@(negedge clk);
			assert (pc == pc_m) else report_mismatch("halted pc", pc_m, pc);
			assert (halted == 1'b1) else report_mismatch("halted level", 1, halted);
			assert (wb.valid == 1'b0) else report_mismatch("halted wb.valid", 0, wb.valid);
		end
		@(posedge clk);
		instr_valid <= 1'b0;
		@(negedge clk);
		for (int i = 0; i < 32; i++) begin
			assert (uut.u_regfile.regs[i] == regs_m[i])
				else report_mismatch("halted register", regs_m[i], uut.u_regfile.regs[i]);
		end
	endtask

	// ==========================================================================
	// main sequence
	// ==========================================================================

	initial begin
		logic [4:0] r;
		seed = 56996;
		rst_n = 1'b0;
		instr = '0;
		instr_valid = 1'b0;
		pc_m = '0;
		halt_m = 1'b0;
		for (int i = 0; i < 32; i++)
			regs_m[i] = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (ready == 1'b1) else report_mismatch("reset ready", 1, ready);
		assert (halted == 1'b0) else report_mismatch("reset halted", 0, halted);
		assert (wb.valid == 1'b0) else report_mismatch("reset wb.valid", 0, wb.valid);
		assert (pc == '0) else report_mismatch("reset pc", 0, pc);
		// add rN, rN, x0 reads back every register
		for (int i = 0; i < 32; i++) begin
			r = i;
			run_instr("reset_read", r_format(7'd0, 5'd0, r, 3'b000, r, rv64_pkg::op_op), 1'b0);
		end
		seed_registers();
		random_alu_program(200);
		immediate_cases();
		control_flow_cases();
		mul_cases();
		ebreak_cases();
		$display("Verification passed");
		$finish;
	end

endmodule

//--- rv64_exec.f
hdl/rv64_pkg.sv
hdl/rv64_decode.sv
hdl/rv64_regfile.sv
hdl/rv64_alu.sv
hdl/rv64_step_counter.sv
hdl/rv64_mul_iter.sv
hdl/rv64_ctrl_fsm.sv
hdl/rv64_exec_top.sv
dv/rv64_exec_tb.sv
